// ==== verilog/mm_word_pkg.sv ====
package mm_word_pkg;

	localparam int WORD_W = 32;
	localparam int DIM_W = WORD_W / 4;

	localparam int unsigned HDR_ADDR = 0;
	localparam int unsigned DATA_BASE = 2; // address 1 reserved

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [DIM_W-1:0] dim_t;

	// m1 sits in the top byte of the header word
	typedef struct packed {
		dim_t m1;
		dim_t n1;
		dim_t m2;
		dim_t n2;
	} mm_header_t;

	typedef union packed {
		word_t raw;
		mm_header_t hdr;
	} mm_word_u;

	typedef struct packed {
		word_t e11;
		word_t e12;
		word_t e21;
		word_t e22;
	} tile_t;

endpackage

// ==== verilog/mm_ctrl_pkg.sv ====
package mm_ctrl_pkg;

	localparam int ADDR_W = 16; // covers the largest ram depth

	typedef logic [ADDR_W-1:0] addr_t;

	typedef enum logic [2:0] {
		S_IDLE,
		S_HEADER,
		S_CHECK,
		S_FETCH,
		S_MAC,
		S_ACC,
		S_WB,
		S_FINISH
	} mm_state_e;

	typedef enum logic [1:0] {STEP_K, STEP_J, STEP_I} step_e;

	typedef struct packed {
		logic we;
		addr_t addr;
		mm_word_pkg::word_t wdata;
	} ram_req_t;

endpackage

// ==== verilog/mm_addr_gen.sv ====
`timescale 1ns/100ps

module mm_addr_gen #(
	parameter int RAM_DEPTH = 512
) (
	input  logic clk,
	input  logic rst,
	input  logic init_i,
	input  mm_word_pkg::mm_header_t hdr_i,
	input  logic step_i,
	output mm_ctrl_pkg::addr_t [3:0] a_addr_o,
	output mm_ctrl_pkg::addr_t [3:0] b_addr_o,
	output mm_ctrl_pkg::addr_t [3:0] c_addr_o,
	output logic last_k_o,
	output logic last_o
);
	import mm_word_pkg::*;
	import mm_ctrl_pkg::*;

	localparam addr_t C_TOP = addr_t'(RAM_DEPTH - 1);
	localparam addr_t TWO = addr_t'(2);

	dim_t i_q, j_q, k_q;
	dim_t lim_i, lim_j, lim_k;
	addr_t n1_q, m2_q, n2_q;
	addr_t a_base, b_base, c_base;
	addr_t b_start; // column rewind on i step
	addr_t b_first;
	step_e kind;

	assign b_first = addr_t'(DATA_BASE) + addr_t'(hdr_i.m1) * addr_t'(hdr_i.n1);

	assign last_k_o = k_q == lim_k;
	assign last_o = last_k_o && j_q == lim_j && i_q == lim_i;

	always_comb
	begin
		if (!last_k_o)
			kind = STEP_K;
		else if (j_q != lim_j)
			kind = STEP_J;
		else
			kind = STEP_I;
	end

	always_ff @(posedge clk)
	begin
		if (rst || init_i)
		begin
			i_q <= '0;
			j_q <= '0;
			k_q <= '0;
		end
		else if (step_i)
		begin
			case (kind)
				STEP_K: k_q <= k_q + 1'b1;
				STEP_J:
				begin
					k_q <= '0;
					j_q <= j_q + 1'b1;
				end
				default:
				begin
					k_q <= '0;
					j_q <= '0;
					i_q <= i_q + 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			lim_i <= '0;
			lim_j <= '0;
			lim_k <= '0;
		end
		else if (init_i)
		begin
			lim_i <= (hdr_i.m1 >> 1) - 1'b1;
			lim_j <= (hdr_i.n2 >> 1) - 1'b1;
			lim_k <= (hdr_i.n1 >> 1) - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (init_i)
		begin
			n1_q <= addr_t'(hdr_i.n1);
			m2_q <= addr_t'(hdr_i.m2);
			n2_q <= addr_t'(hdr_i.n2);
			a_base <= addr_t'(DATA_BASE);
			b_base <= b_first;
			b_start <= b_first;
			c_base <= C_TOP;
		end
		else if (step_i)
		begin
			case (kind)
				STEP_K:
				begin
					a_base <= a_base + TWO;
					b_base <= b_base + TWO;
				end
				STEP_J:
				begin
					a_base <= a_base - n1_q + TWO; // back to row start
					b_base <= b_base + m2_q + TWO;
					c_base <= c_base - TWO;
				end
				default:
				begin
					a_base <= a_base + n1_q + TWO;
					b_base <= b_start;
					c_base <= c_base - n2_q - TWO;
				end
			endcase
		end
	end

	// A row-major, B column-major, C downward from the top
	assign a_addr_o = {a_base + n1_q + 1'b1, a_base + n1_q, a_base + 1'b1, a_base};
	assign b_addr_o = {b_base + m2_q + 1'b1, b_base + 1'b1, b_base + m2_q, b_base};
	assign c_addr_o = {c_base - n2_q - 1'b1, c_base - n2_q, c_base - 1'b1, c_base};

endmodule

// ==== verilog/mm_block_mac.sv ====
`timescale 1ns/100ps

module mm_block_mac (
	input  logic clk,
	input  logic rst,
	input  logic mac_start_i,
	input  mm_word_pkg::tile_t a_i,
	input  mm_word_pkg::tile_t b_i,
	output mm_word_pkg::tile_t prod_o,
	output logic prod_valid_o
);
	import mm_word_pkg::*;

	// row times column wrapping at word width
	function automatic word_t dot(input word_t x0, input word_t x1,
		input word_t y0, input word_t y1);
		return x0 * y0 + x1 * y1;
	endfunction

	always_ff @(posedge clk)
	begin
		if (mac_start_i)
		begin
			prod_o.e11 <= dot(a_i.e11, a_i.e12, b_i.e11, b_i.e21);
			prod_o.e12 <= dot(a_i.e11, a_i.e12, b_i.e12, b_i.e22);
			prod_o.e21 <= dot(a_i.e21, a_i.e22, b_i.e11, b_i.e21);
			prod_o.e22 <= dot(a_i.e21, a_i.e22, b_i.e12, b_i.e22);
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			prod_valid_o <= 1'b0;
		else
			prod_valid_o <= mac_start_i;
	end

endmodule

// ==== verilog/mm_block_acc.sv ====
`timescale 1ns/100ps

module mm_block_acc (
	input  logic clk,
	input  logic rst,
	input  logic clear_i,
	input  logic add_i,
	input  mm_word_pkg::tile_t prod_i,
	output mm_word_pkg::tile_t acc_o
);
	import mm_word_pkg::*;

	tile_t acc_q;

	always_ff @(posedge clk)
	begin
		if (rst || clear_i)
		begin
			acc_q <= '0; // clear wins over add
		end
		else if (add_i)
		begin
			acc_q.e11 <= acc_q.e11 + prod_i.e11;
			acc_q.e12 <= acc_q.e12 + prod_i.e12;
			acc_q.e21 <= acc_q.e21 + prod_i.e21;
			acc_q.e22 <= acc_q.e22 + prod_i.e22;
		end
	end

	assign acc_o = acc_q;

endmodule

// ==== verilog/mm_sequencer.sv ====
`timescale 1ns/100ps

module mm_sequencer (
	input  logic clk,
	input  logic rst,
	input  logic start_i,
	input  mm_word_pkg::mm_word_u ram_rdata_i,
	output mm_ctrl_pkg::ram_req_t ram_req_o,
	output mm_word_pkg::mm_header_t hdr_o,
	output logic init_o,
	output logic step_o,
	input  mm_ctrl_pkg::addr_t [3:0] a_addr_i,
	input  mm_ctrl_pkg::addr_t [3:0] b_addr_i,
	input  mm_ctrl_pkg::addr_t [3:0] c_addr_i,
	input  logic last_k_i,
	input  logic last_o_i,
	output mm_word_pkg::tile_t a_tile_o,
	output mm_word_pkg::tile_t b_tile_o,
	output logic mac_start_o,
	input  logic prod_valid_i,
	input  mm_word_pkg::tile_t acc_i,
	output logic clear_o,
	output logic done_o,
	output logic err_o
);
	import mm_word_pkg::*;
	import mm_ctrl_pkg::*;

	mm_state_e state_q;
	logic [3:0] sub_q; // fetch 0..8, write-back 0..3
	tile_t a_q, b_q;
	mm_header_t hdr;
	logic hdr_ok;
	logic wb_last;

	assign hdr = ram_rdata_i.hdr;

	// zero dims rejected too since the tile walk needs one tile at least
	assign hdr_ok = hdr.n1 == hdr.m2 && !(hdr.m1[0] | hdr.n1[0] | hdr.m2[0] | hdr.n2[0])
		&& hdr.m1 != '0 && hdr.n1 != '0 && hdr.n2 != '0;

	assign wb_last = state_q == S_WB && sub_q == 4'd3;

	assign hdr_o = hdr;
	assign init_o = state_q == S_CHECK && hdr_ok;
	assign err_o = state_q == S_CHECK && !hdr_ok;
	assign done_o = state_q == S_FINISH;
	assign mac_start_o = state_q == S_MAC;
	assign step_o = (state_q == S_ACC && prod_valid_i && !last_k_i) || (wb_last && !last_o_i);
	assign clear_o = init_o || wb_last;
	assign a_tile_o = a_q;
	assign b_tile_o = b_q;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state_q <= S_IDLE;
			sub_q <= '0;
		end
		else
		begin
			case (state_q)
				S_IDLE: if (start_i) state_q <= S_HEADER;
				S_HEADER: state_q <= S_CHECK;
				S_CHECK:
				begin
					sub_q <= '0;
					state_q <= hdr_ok ? S_FETCH : S_IDLE;
				end
				S_FETCH:
				begin
					sub_q <= sub_q == 4'd8 ? 4'd0 : sub_q + 1'b1;
					if (sub_q == 4'd8)
						state_q <= S_MAC;
				end
				S_MAC: state_q <= S_ACC;
				S_ACC: if (prod_valid_i) state_q <= last_k_i ? S_WB : S_FETCH;
				S_WB:
				begin
					sub_q <= wb_last ? 4'd0 : sub_q + 1'b1;
					if (wb_last)
						state_q <= last_o_i ? S_FINISH : S_FETCH;
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// read data lags the address by one cycle
	always_ff @(posedge clk)
	begin
		if (state_q == S_FETCH)
		begin
			case (sub_q)
				4'd1: a_q.e11 <= ram_rdata_i.raw;
				4'd2: a_q.e12 <= ram_rdata_i.raw;
				4'd3: a_q.e21 <= ram_rdata_i.raw;
				4'd4: a_q.e22 <= ram_rdata_i.raw;
				4'd5: b_q.e11 <= ram_rdata_i.raw;
				4'd6: b_q.e12 <= ram_rdata_i.raw;
				4'd7: b_q.e21 <= ram_rdata_i.raw;
				4'd8: b_q.e22 <= ram_rdata_i.raw;
				default: a_q <= a_q;
			endcase
		end
	end

	always_comb
	begin
		ram_req_o = '0;
		ram_req_o.addr = addr_t'(HDR_ADDR);
		if (state_q == S_FETCH && sub_q < 4'd4)
			ram_req_o.addr = a_addr_i[sub_q[1:0]];
		else if (state_q == S_FETCH && sub_q < 4'd8)
			ram_req_o.addr = b_addr_i[sub_q[1:0]];
		else if (state_q == S_WB)
		begin
			ram_req_o.we = 1'b1;
			ram_req_o.addr = c_addr_i[sub_q[1:0]];
			case (sub_q[1:0])
				2'd0: ram_req_o.wdata = acc_i.e11;
				2'd1: ram_req_o.wdata = acc_i.e12;
				2'd2: ram_req_o.wdata = acc_i.e21;
				default: ram_req_o.wdata = acc_i.e22;
			endcase
		end
	end

endmodule

// ==== verilog/mm_top.sv ====
`timescale 1ns/100ps

module mm_top #(
	parameter int RAM_DEPTH = 512
) (
	input  logic clk,
	input  logic rst,
	input  logic start_i,
	input  mm_word_pkg::word_t ram_rdata_i,
	output mm_ctrl_pkg::ram_req_t ram_req_o,
	output logic done_o,
	output logic err_o
);
	import mm_word_pkg::*;
	import mm_ctrl_pkg::*;

	mm_header_t hdr;
	logic init, step, last_k, last;
	addr_t [3:0] a_addr, b_addr, c_addr;
	tile_t a_tile, b_tile, prod, acc;
	logic mac_start, prod_valid, clear;

	mm_sequencer seq0 (
		.clk(clk), .rst(rst), .start_i(start_i),
		.ram_rdata_i(ram_rdata_i), .ram_req_o(ram_req_o),
		.hdr_o(hdr), .init_o(init), .step_o(step),
		.a_addr_i(a_addr), .b_addr_i(b_addr), .c_addr_i(c_addr),
		.last_k_i(last_k), .last_o_i(last),
		.a_tile_o(a_tile), .b_tile_o(b_tile), .mac_start_o(mac_start),
		.prod_valid_i(prod_valid), .acc_i(acc), .clear_o(clear),
		.done_o(done_o), .err_o(err_o)
	);

	mm_addr_gen #(.RAM_DEPTH(RAM_DEPTH)) agen0 (
		.clk(clk), .rst(rst), .init_i(init), .hdr_i(hdr), .step_i(step),
		.a_addr_o(a_addr), .b_addr_o(b_addr), .c_addr_o(c_addr),
		.last_k_o(last_k), .last_o(last)
	);

	mm_block_mac mac0 (
		.clk(clk), .rst(rst), .mac_start_i(mac_start), .a_i(a_tile), .b_i(b_tile),
		.prod_o(prod), .prod_valid_o(prod_valid)
	);

	mm_block_acc acc0 (
		.clk(clk), .rst(rst), .clear_i(clear), .add_i(prod_valid),
		.prod_i(prod), .acc_o(acc)
	);

endmodule

// ==== tests/mm_tb_clk.sv ====
`timescale 1ns/100ps

module mm_tb_clk #(
	parameter int PERIOD_NS = 4,
	parameter int RST_CYCLES = 10
) (
	output logic clk_o,
	output logic rst_o
);

	initial
	begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	initial
	begin
		rst_o = 1'b1;
		repeat (RST_CYCLES) @(posedge clk_o);
		#1 rst_o = 1'b0; // released 1 ns after the edge
	end

endmodule

// ==== tests/mm_ram_model.sv ====
`timescale 1ns/100ps

module mm_ram_model #(
	parameter int DEPTH = 512
) (
	input  logic clk,
	input  mm_ctrl_pkg::ram_req_t req_i,
	output mm_word_pkg::word_t rdata_o
);
	import mm_word_pkg::*;

	localparam int AW = $clog2(DEPTH);

	word_t mem [DEPTH];

	// read sees the old word before the write lands
	always @(posedge clk)
	begin
		rdata_o <= mem[req_i.addr[AW-1:0]];
		if (req_i.we)
			mem[req_i.addr[AW-1:0]] = req_i.wdata;
	end

	task automatic load_word(input int addr, input word_t data);
		mem[addr[AW-1:0]] = data;
	endtask

	function automatic word_t peek_word(input int addr);
		return mem[addr[AW-1:0]];
	endfunction

endmodule

// ==== tests/mm_tb.sv ====
`timescale 1ns/100ps

module mm_tb;
	import mm_word_pkg::*;
	import mm_ctrl_pkg::*;

	localparam int DEPTH = 512;
	localparam int MAX_WAIT = 2000; // cycles per run
	// 8x8x8 needs 64 steps of 11 cycles plus 16 write-backs per run
	localparam int WATCHDOG_NS = 200_000;

	logic clk, rst, start;
	ram_req_t ram_req;
	word_t ram_rdata;
	logic done, err;

	int errors = 0;
	int done_cnt = 0;
	int err_cnt = 0;
	int c_low = DEPTH; // lowest legal write address
	logic armed = 1'b0; // start issued and result not yet seen
	logic expect_err = 1'b0;
	word_t a_m [8][8];
	word_t b_m [8][8];
	word_t img [DEPTH]; // expected RAM contents

	mm_tb_clk clk0 (.clk_o(clk), .rst_o(rst));

	mm_ram_model #(.DEPTH(DEPTH)) ram0 (.clk(clk), .req_i(ram_req), .rdata_o(ram_rdata));

	mm_top #(.RAM_DEPTH(DEPTH)) dut0 (
		.clk(clk), .rst(rst), .start_i(start), .ram_rdata_i(ram_rdata),
		.ram_req_o(ram_req), .done_o(done), .err_o(err)
	);

	task automatic report_failure(input string what);
		errors++;
		$display("%s at %0t", what, $time);
	endtask

	assert property (@(posedge clk) disable iff (rst) !(done && err))
		else report_failure("done and err high in the same cycle");
	assert property (@(posedge clk) disable iff (rst) !armed |-> !(done || err || ram_req.we))
		else report_failure("done, err or write without a start");
	assert property (@(posedge clk) disable iff (rst)
		ram_req.we |-> int'(ram_req.addr) >= c_low && int'(ram_req.addr) < DEPTH)
		else report_failure("write outside the C region");
	assert property (@(posedge clk) disable iff (rst) expect_err |-> !(done || ram_req.we))
		else report_failure("done or write on a rejected header");

	always @(negedge clk)
	begin
		if (done)
			done_cnt++;
		if (err)
			err_cnt++;
	end

	task automatic expect_eq(input string name, input word_t got, input word_t exp);
		assert (got == exp)
		else
		begin
			errors++;
			$display("Error at %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic put_word(input int addr, input word_t data);
		img[addr] = data;
		ram0.load_word(addr, data);
	endtask

	task automatic load_case(input int m1, input int n1, input int m2, input int n2);
		for (int a = 0; a < DEPTH; a++)
			put_word(a, word_t'(a) * 32'h9e37_79b9 ^ 32'h0bad_f00d);
		put_word(HDR_ADDR, {m1[7:0], n1[7:0], m2[7:0], n2[7:0]});
		for (int r = 0; r < m1; r++)
			for (int c = 0; c < n1; c++)
			begin
				a_m[r][c] = $urandom;
				put_word(DATA_BASE + r * n1 + c, a_m[r][c]);
			end
		for (int r = 0; r < m2; r++)
			for (int c = 0; c < n2; c++)
			begin
				b_m[r][c] = $urandom;
				put_word(DATA_BASE + m1 * n1 + c * m2 + r, b_m[r][c]);
			end
	endtask

	task automatic start_and_wait();
		int cycles;
		done_cnt = 0;
		err_cnt = 0;
		@(posedge clk);
		#1;
		start = 1'b1;
		armed = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		cycles = 0;
		while (!(done || err) && cycles < MAX_WAIT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (cycles >= MAX_WAIT)
			report_failure($sformatf("no done or err within %0d cycles", MAX_WAIT));
		repeat (3) @(negedge clk); // catch any extra pulse
		armed = 1'b0;
	endtask

	task automatic multiply(input int m1, input int n1, input int n2);
		word_t acc;
		load_case(m1, n1, n1, n2);
		c_low = DEPTH - m1 * n2;
		start_and_wait();
		expect_eq("done_o pulses", word_t'(done_cnt), 1);
		expect_eq("err_o pulses", word_t'(err_cnt), 0);
		for (int r = 0; r < m1; r++)
			for (int c = 0; c < n2; c++)
			begin
				acc = '0;
				for (int k = 0; k < n1; k++)
					acc += a_m[r][k] * b_m[k][c];
				expect_eq($sformatf("C[%0d][%0d]", r, c),
					ram0.peek_word(DEPTH - 1 - (r * n2 + c)), acc);
			end
		for (int a = 0; a < c_low; a++)
			expect_eq($sformatf("mem[%0d]", a), ram0.peek_word(a), img[a]);
	endtask

	task automatic reject(input int m1, input int n1, input int m2, input int n2);
		load_case(m1, n1, m2, n2);
		c_low = DEPTH;
		expect_err = 1'b1;
		start_and_wait();
		expect_err = 1'b0;
		expect_eq("err_o pulses", word_t'(err_cnt), 1);
		expect_eq("done_o pulses", word_t'(done_cnt), 0);
	endtask

	function automatic int rnd_dim();
		return 2 * (1 + $urandom % 4);
	endfunction

	initial
	begin
		start = 1'b0;
		void'($urandom(40));
		@(negedge rst);
		multiply(2, 2, 2);
		multiply(4, 6, 4); // k, j and i steps
		reject(2, 4, 2, 2);
		reject(3, 2, 2, 2);
		repeat (5) multiply(rnd_dim(), rnd_dim(), rnd_dim());
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired before all runs finished");
		$display("errors: %0d", errors + 1);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== mm.f ====
verilog/mm_word_pkg.sv
verilog/mm_ctrl_pkg.sv
verilog/mm_addr_gen.sv
verilog/mm_block_mac.sv
verilog/mm_block_acc.sv
verilog/mm_sequencer.sv
verilog/mm_top.sv
tests/mm_tb_clk.sv
tests/mm_ram_model.sv
tests/mm_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps --top-module mm_tb -f mm.f

out="$(./obj_dir/Vmm_tb)"
echo "$out"

if echo "$out" | grep -q "SIMULATION PASSED"; then
	exit 0
fi
exit 1
